/* files.f */
hdl/raster_pkg.sv
hdl/raster_mem.sv
hdl/raster_edge_eval.sv
hdl/raster_slice.sv
hdl/raster_unit.sv
test/raster_tb_memory.sv
test/raster_unit_tb.sv

/* hdl/raster_edge_eval.sv */
`timescale 1ns/1ps
`default_nettype none

module raster_edge_eval import raster_pkg::*; (
    input  logic         clk,
    input  logic         reset,

    input  logic         prim_valid,
    input  raster_prim_t prim,
    output logic         prim_ready,

    output logic         eval_valid,
    output raster_eval_t eval,
    input  logic         eval_ready
);

    logic               enable;
    logic               valid1;
    raster_prim_t       prim1;
    raster_data_t [2:0] prod_a;
    raster_data_t [2:0] prod_b;
    raster_data_t       x0;
    raster_data_t       y0;

    // Whole pipe freezes under back-pressure
    assign enable     = !(eval_valid && !eval_ready);
    assign prim_ready = enable;

    // Tile origin in pixels
    assign x0 = raster_data_t'(prim.x_loc) << TILE_LOGSIZE;
    assign y0 = raster_data_t'(prim.y_loc) << TILE_LOGSIZE;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid1     <= 1'b0;
            eval_valid <= 1'b0;
        end else if (enable) begin
            valid1     <= prim_valid;
            eval_valid <= valid1;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            prim1     <= prim;
            eval.prim <= prim1;
            for (int i = 0; i < 3; i++) begin
                prod_a[i]   <= prim.edges[i].a * x0;
                prod_b[i]   <= prim.edges[i].b * y0;
                eval.org[i] <= prod_a[i] + prod_b[i] + prim1.edges[i].c;
            end
        end
    end

    a_eval_hold: assert property (@(posedge clk) disable iff (reset)
        eval_valid && !eval_ready |=> eval_valid && $stable(eval));

endmodule

`default_nettype wire

/* hdl/raster_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module raster_mem import raster_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          start,
    input  raster_dcrs_t  dcrs,
    output logic          busy,

    output logic          cache_req_valid,
    output cache_req_t    cache_req,
    input  logic          cache_req_ready,

    input  logic          cache_rsp_valid,
    input  cache_rsp_t    cache_rsp,
    output logic          cache_rsp_ready,

    output logic          prim_valid,
    output raster_prim_t  prim,
    input  logic          prim_ready
);

    logic [15:0]               rec_left;    // records not yet handed off
    raster_addr_t              rec_addr;
    logic [WORD_IDX_BITS-1:0]  req_idx;
    logic [WORD_IDX_BITS-1:0]  rsp_idx;
    logic [MEM_CNT_BITS-1:0]   pending;
    raster_word_t [PRIM_WORDS-1:0] words;

    logic req_fire;
    logic rsp_fire;
    logic prim_fire;

    assign req_fire  = cache_req_valid && cache_req_ready;
    assign rsp_fire  = cache_rsp_valid && cache_rsp_ready;
    assign prim_fire = prim_valid && prim_ready;

    assign busy = start || (rec_left != '0);

    // One record at a time, bounded by the read queue
    assign cache_req_valid = (rec_left != '0)
                          && !prim_valid
                          && (req_idx < WORD_IDX_BITS'(PRIM_WORDS))
                          && (pending < MEM_CNT_BITS'(MEM_QUEUE_DEPTH));

    assign cache_req.addr  = rec_addr + (raster_addr_t'(req_idx) << 2);
    assign cache_rsp_ready = 1'b1;  // words always absorbed

    always_ff @(posedge clk) begin
        if (reset) begin
            rec_left   <= '0;
            req_idx    <= '0;
            rsp_idx    <= '0;
            pending    <= '0;
            prim_valid <= 1'b0;
        end else begin
            if (start) begin
                rec_left <= dcrs.prim_count;
            end
            if (req_fire) begin
                req_idx <= req_idx + 1'b1;
            end
            if (rsp_fire) begin
                rsp_idx <= rsp_idx + 1'b1;
                if (rsp_idx == WORD_IDX_BITS'(PRIM_WORDS - 1)) begin
                    prim_valid <= 1'b1;
                end
            end
            pending <= pending + MEM_CNT_BITS'(req_fire) - MEM_CNT_BITS'(rsp_fire);
            if (prim_fire) begin
                prim_valid <= 1'b0;
                req_idx    <= '0;
                rsp_idx    <= '0;
                rec_left   <= rec_left - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rec_addr <= dcrs.prim_base;
        end else if (prim_fire) begin
            rec_addr <= rec_addr + raster_addr_t'(RECORD_BYTES);
        end
        if (rsp_fire) begin
            words <= {cache_rsp.data, words[PRIM_WORDS-1:1]};  // word 0 ends at the bottom
        end
    end

    always_comb begin
        prim.x_loc = words[0][31:24];
        prim.y_loc = words[0][23:16];
        prim.pid   = words[0][15:0];
        for (int i = 0; i < 3; i++) begin
            prim.edges[i].a = words[1 + 3 * i];
            prim.edges[i].b = words[2 + 3 * i];
            prim.edges[i].c = words[3 + 3 * i];
        end
    end

    a_pending_max: assert property (@(posedge clk) disable iff (reset)
        pending <= MEM_CNT_BITS'(MEM_QUEUE_DEPTH));

    // A response needs a request in flight
    a_pending_min: assert property (@(posedge clk) disable iff (reset)
        rsp_fire |-> (pending != '0 || req_fire));

endmodule

`default_nettype wire

/* hdl/raster_pkg.sv */
`default_nettype none

package raster_pkg;

    // Tile geometry
    localparam int TILE_LOGSIZE    = 3;
    localparam int QUADS_PER_SIDE  = 1 << (TILE_LOGSIZE - 1);
    localparam int QUAD_BITS       = TILE_LOGSIZE - 1;

    // Memory fetch
    localparam int MEM_QUEUE_DEPTH = 4;
    localparam int MEM_CNT_BITS    = $clog2(MEM_QUEUE_DEPTH + 1);
    localparam int PRIM_WORDS      = 10;
    localparam int WORD_IDX_BITS   = $clog2(PRIM_WORDS + 1);
    localparam int RECORD_BYTES    = PRIM_WORDS * 4;

    localparam int EDGE_LATENCY    = 2;
    localparam int EDGE_CNT_BITS   = $clog2(EDGE_LATENCY + 1);

    typedef logic [31:0]        raster_addr_t;
    typedef logic [31:0]        raster_word_t;
    typedef logic signed [31:0] raster_data_t;
    typedef logic [7:0]         raster_dim_t;
    typedef logic [10:0]        raster_pos_t;
    typedef logic [15:0]        raster_pid_t;
    typedef logic [3:0]         raster_mask_t;  // bit0 (0,0) bit1 (1,0) bit2 (0,1) bit3 (1,1)

    typedef struct packed {
        raster_data_t a;
        raster_data_t b;
        raster_data_t c;
    } raster_edge_t;

    typedef struct packed {
        raster_dim_t        x_loc;
        raster_dim_t        y_loc;
        raster_pid_t        pid;
        raster_edge_t [2:0] edges;
    } raster_prim_t;

    // Primitive with edge values at the tile origin
    typedef struct packed {
        raster_prim_t       prim;
        raster_data_t [2:0] org;
    } raster_eval_t;

    typedef struct packed {
        raster_pos_t  pos_x;    // quad top-left pixel
        raster_pos_t  pos_y;
        raster_mask_t mask;
        raster_pid_t  pid;
    } raster_stamp_t;

    typedef struct packed {
        raster_addr_t prim_base;
        logic [15:0]  prim_count;
    } raster_dcrs_t;

    typedef struct packed {
        raster_addr_t addr;
    } cache_req_t;

    typedef struct packed {
        raster_word_t data;
    } cache_rsp_t;

endpackage

`default_nettype wire

/* hdl/raster_slice.sv */
`timescale 1ns/1ps
`default_nettype none

module raster_slice import raster_pkg::*; (
    input  logic          clk,
    input  logic          reset,

    input  logic          eval_valid,
    input  raster_eval_t  eval,
    output logic          eval_ready,

    output logic          idle,
    output logic          stamp_valid,
    output raster_stamp_t stamp,
    input  logic          raster_req_ready
);

    typedef enum logic {IDLE, WALK} slice_state_t;

    slice_state_t         state;
    logic [QUAD_BITS-1:0] qx;
    logic [QUAD_BITS-1:0] qy;

    raster_dim_t          tile_x;
    raster_dim_t          tile_y;
    raster_pid_t          pid;
    raster_data_t [2:0]   edge_a;
    raster_data_t [2:0]   edge_b;
    raster_data_t [2:0]   row_val;  // value at the first quad of the row
    raster_data_t [2:0]   cur_val;  // value at the current quad's (0,0)

    raster_data_t [2:0]   val_x;
    raster_data_t [2:0]   val_y;
    raster_data_t [2:0]   val_xy;
    raster_mask_t         quad_mask;

    logic advance;
    logic last_x;
    logic last_y;

    assign eval_ready = (state == IDLE);
    assign idle       = (state == IDLE) && !stamp_valid;
    assign advance    = !stamp_valid || raster_req_ready;
    assign last_x     = (qx == QUAD_BITS'(QUADS_PER_SIDE - 1));
    assign last_y     = (qy == QUAD_BITS'(QUADS_PER_SIDE - 1));

    // Covered when every edge is non-negative
    always_comb begin
        quad_mask = 4'b1111;
        for (int i = 0; i < 3; i++) begin
            val_x[i]  = cur_val[i] + edge_a[i];
            val_y[i]  = cur_val[i] + edge_b[i];
            val_xy[i] = val_x[i] + edge_b[i];
            quad_mask &= {~val_xy[i][31], ~val_y[i][31], ~val_x[i][31], ~cur_val[i][31]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            qx          <= '0;
            qy          <= '0;
            stamp_valid <= 1'b0;
        end else begin
            if (stamp_valid && raster_req_ready) begin
                stamp_valid <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (eval_valid) begin
                        state <= WALK;
                        qx    <= '0;
                        qy    <= '0;
                    end
                end
                WALK: begin
                    if (advance) begin
                        if (quad_mask != '0) begin
                            stamp_valid <= 1'b1;
                        end
                        if (last_x) begin
                            qx <= '0;
                            qy <= qy + 1'b1;
                            if (last_y) begin
                                state <= IDLE;
                            end
                        end else begin
                            qx <= qx + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && eval_valid) begin
            tile_x <= eval.prim.x_loc;
            tile_y <= eval.prim.y_loc;
            pid    <= eval.prim.pid;
            for (int i = 0; i < 3; i++) begin
                edge_a[i]  <= eval.prim.edges[i].a;
                edge_b[i]  <= eval.prim.edges[i].b;
                row_val[i] <= eval.org[i];
                cur_val[i] <= eval.org[i];
            end
        end else if (state == WALK && advance) begin
            if (quad_mask != '0) begin
                stamp.pos_x <= {tile_x, qx, 1'b0};
                stamp.pos_y <= {tile_y, qy, 1'b0};
                stamp.mask  <= quad_mask;
                stamp.pid   <= pid;
            end
            for (int i = 0; i < 3; i++) begin
                if (last_x) begin
                    row_val[i] <= row_val[i] + (edge_b[i] <<< 1);
                    cur_val[i] <= row_val[i] + (edge_b[i] <<< 1);
                end else begin
                    cur_val[i] <= cur_val[i] + (edge_a[i] <<< 1);
                end
            end
        end
    end

    // Empty quads are skipped by the walk
    a_no_empty_stamp: assert property (@(posedge clk) disable iff (reset)
        stamp_valid |-> stamp.mask != '0);

endmodule

`default_nettype wire

/* hdl/raster_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module raster_unit import raster_pkg::*; (
    input  logic          clk,
    input  logic          reset,

    input  raster_dcrs_t  dcrs,

    output logic          cache_req_valid,
    output cache_req_t    cache_req,
    input  logic          cache_req_ready,

    input  logic          cache_rsp_valid,
    input  cache_rsp_t    cache_rsp,
    output logic          cache_rsp_ready,

    output logic          raster_req_valid,
    output raster_stamp_t raster_req_stamp,
    output logic          raster_req_empty,
    input  logic          raster_req_ready
);

    logic         start;
    logic         mem_busy;

    logic         prim_valid;
    raster_prim_t prim;
    logic         prim_ready;

    logic         eval_valid;
    raster_eval_t eval;
    logic         eval_ready;

    logic         slice_idle;
    logic         stamp_valid;

    logic [EDGE_CNT_BITS-1:0] pipe_cnt;   // items inside the edge pipeline
    logic         prim_fire;
    logic         eval_fire;
    logic         drained;

    always_ff @(posedge clk) begin
        start <= reset;     // kicks the fetch right after reset
    end

    raster_mem mem (
        .clk             (clk),
        .reset           (reset),
        .start           (start),
        .dcrs            (dcrs),
        .busy            (mem_busy),
        .cache_req_valid (cache_req_valid),
        .cache_req       (cache_req),
        .cache_req_ready (cache_req_ready),
        .cache_rsp_valid (cache_rsp_valid),
        .cache_rsp       (cache_rsp),
        .cache_rsp_ready (cache_rsp_ready),
        .prim_valid      (prim_valid),
        .prim            (prim),
        .prim_ready      (prim_ready)
    );

    raster_edge_eval edge_eval (
        .clk        (clk),
        .reset      (reset),
        .prim_valid (prim_valid),
        .prim       (prim),
        .prim_ready (prim_ready),
        .eval_valid (eval_valid),
        .eval       (eval),
        .eval_ready (eval_ready)
    );

    raster_slice slice (
        .clk              (clk),
        .reset            (reset),
        .eval_valid       (eval_valid),
        .eval             (eval),
        .eval_ready       (eval_ready),
        .idle             (slice_idle),
        .stamp_valid      (stamp_valid),
        .stamp            (raster_req_stamp),
        .raster_req_ready (raster_req_ready)
    );

    assign prim_fire = prim_valid && prim_ready;
    assign eval_fire = eval_valid && eval_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            pipe_cnt <= '0;
        end else begin
            pipe_cnt <= pipe_cnt + EDGE_CNT_BITS'(prim_fire) - EDGE_CNT_BITS'(eval_fire);
        end
    end

    assign drained = !mem_busy && !prim_valid && (pipe_cnt == '0) && slice_idle;

    // Sticky end-of-work marker
    always_ff @(posedge clk) begin
        if (reset) begin
            raster_req_empty <= 1'b0;
        end else if (drained) begin
            raster_req_empty <= 1'b1;
        end
    end

    assign raster_req_valid = stamp_valid || raster_req_empty;

    a_pipe_bound: assert property (@(posedge clk) disable iff (reset)
        pipe_cnt <= EDGE_CNT_BITS'(EDGE_LATENCY));

    // Nothing moves once the marker is up
    a_empty_final: assert property (@(posedge clk) disable iff (reset)
        raster_req_empty |-> !stamp_valid && !cache_req_valid && !prim_valid);

endmodule

`default_nettype wire

/* test/raster_tb_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module raster_tb_memory import raster_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       req_valid,
    input  cache_req_t req,
    output logic       req_ready,
    output logic       rsp_valid,
    output cache_rsp_t rsp,
    input  logic       rsp_ready
);

    raster_word_t words [0:255];
    int           req_count;    // requests accepted since reset

    raster_word_t rsp_data [$];
    int           rsp_due [$];  // cycle from which each response may be shown
    int           cycle;
    int           last_due;
    logic [31:0]  lcg_state;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            words[i] = {~16'(i), 16'(i * 3 + 1)};
        end
        lcg_state = 32'd45749;
        cycle     = 0;
        last_due  = 0;
        req_count = 0;
        req_ready = 1'b1;
        rsp_valid = 1'b0;
        rsp       = '0;
    end

    always @(posedge clk) begin
        int lat;
        cycle++;
        if (reset) begin
            rsp_data.delete();
            rsp_due.delete();
            req_count = 0;
            last_due  = cycle;
        end else begin
            if (rsp_valid && rsp_ready) begin
                void'(rsp_data.pop_front());
                void'(rsp_due.pop_front());
            end
            if (req_valid && req_ready) begin
                lcg_state = lcg_next(lcg_state);
                lat       = int'(lcg_state[30:16] % 6);
                // No earlier than the previous response
                if (cycle + lat > last_due) begin
                    last_due = cycle + lat;
                end
                rsp_data.push_back(words[req.addr[9:2]]);
                rsp_due.push_back(last_due);
                req_count++;
            end
        end
        #2;
        rsp_valid = (rsp_due.size() != 0) && (rsp_due[0] <= cycle);
        rsp.data  = (rsp_data.size() != 0) ? rsp_data[0] : '0;
    end

endmodule

`default_nettype wire

/* test/raster_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module raster_unit_tb import raster_pkg::*; ();

    localparam int NUM_TESTS   = 5;
    localparam int MAX_PRIMS   = 3;
    localparam int CYCLE_NS    = 20;
    localparam int HOLD_CYCLES = 8;

    typedef struct packed {
        raster_addr_t                 base;
        logic [15:0]                  count;
        logic [7:0]                   bp_pct;   // Percent chance of ready low
        raster_prim_t [MAX_PRIMS-1:0] prims;
    } test_t;

    logic          clk = 1'b0;
    logic          reset;
    raster_dcrs_t  dcrs;
    logic          cache_req_valid;
    cache_req_t    cache_req;
    logic          cache_req_ready;
    logic          cache_rsp_valid;
    cache_rsp_t    cache_rsp;
    logic          cache_rsp_ready;
    logic          raster_req_valid;
    raster_stamp_t raster_req_stamp;
    logic          raster_req_empty;
    logic          raster_req_ready;

    test_t         tests [NUM_TESTS];
    raster_stamp_t expected [$];
    logic [31:0]   rnd;
    int            errors;
    int            failed;

    always #(CYCLE_NS / 2) clk = ~clk;

    raster_unit DUT (
        .clk              (clk),
        .reset            (reset),
        .dcrs             (dcrs),
        .cache_req_valid  (cache_req_valid),
        .cache_req        (cache_req),
        .cache_req_ready  (cache_req_ready),
        .cache_rsp_valid  (cache_rsp_valid),
        .cache_rsp        (cache_rsp),
        .cache_rsp_ready  (cache_rsp_ready),
        .raster_req_valid (raster_req_valid),
        .raster_req_stamp (raster_req_stamp),
        .raster_req_empty (raster_req_empty),
        .raster_req_ready (raster_req_ready)
    );

    raster_tb_memory memory (
        .clk       (clk),
        .reset     (reset),
        .req_valid (cache_req_valid),
        .req       (cache_req),
        .req_ready (cache_req_ready),
        .rsp_valid (cache_rsp_valid),
        .rsp       (cache_rsp),
        .rsp_ready (cache_rsp_ready)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic raster_edge_t edge_from(input int a, input int b, input int c);
        raster_edge_t e;
        e.a = a;
        e.b = b;
        e.c = c;
        return e;
    endfunction

    function automatic raster_prim_t prim_at(input int x, input int y, input int pid,
            input raster_edge_t e0, input raster_edge_t e1, input raster_edge_t e2);
        raster_prim_t p;
        p.x_loc    = raster_dim_t'(x);
        p.y_loc    = raster_dim_t'(y);
        p.pid      = raster_pid_t'(pid);
        p.edges[0] = e0;
        p.edges[1] = e1;
        p.edges[2] = e2;
        return p;
    endfunction

    function automatic void fill_table();
        tests = '{default: '0};
        // Partial triangle in tile (1,2)
        tests[0].base     = 32'h100;
        tests[0].count    = 1;
        tests[0].prims[0] = prim_at(1, 2, 16'h0011, edge_from(1, 0, -9),
                                    edge_from(0, 1, -17), edge_from(-1, -1, 30));
        // Three tiles in record order
        tests[1].base     = 32'h200;
        tests[1].count    = 3;
        tests[1].prims[0] = prim_at(0, 0, 7, edge_from(1, -1, 0),
                                    edge_from(0, 0, 1), edge_from(0, 0, 1));
        tests[1].prims[1] = prim_at(3, 1, 8, edge_from(-1, 0, 27),
                                    edge_from(0, 1, -10), edge_from(0, 0, 1));
        tests[1].prims[2] = prim_at(2, 2, 9, edge_from(-2, -1, 60),
                                    edge_from(1, 0, -17), edge_from(0, 0, 1));
        // One outside its tile and one fully covered
        tests[2].base     = 32'h300;
        tests[2].count    = 2;
        tests[2].prims[0] = prim_at(0, 0, 16'h0020, edge_from(1, 0, -100),
                                    edge_from(0, 0, 1), edge_from(0, 0, 1));
        tests[2].prims[1] = prim_at(5, 5, 16'h0021, edge_from(1, 0, 0),
                                    edge_from(0, 1, 0), edge_from(-1, -1, 200));
        // Same records as test 1 under back-pressure
        tests[3]          = tests[1];
        tests[3].base     = 32'h080;
        tests[3].bp_pct   = 50;
        tests[4].base     = 32'h000;
        tests[4].count    = 0;
        tests[4].bp_pct   = 50;
    endfunction

    task automatic store_records(input test_t t);
        int w;
        for (int n = 0; n < MAX_PRIMS; n++) begin
            w = int'(t.base >> 2) + n * PRIM_WORDS;
            memory.words[w] = {t.prims[n].x_loc, t.prims[n].y_loc, t.prims[n].pid};
            for (int i = 0; i < 3; i++) begin
                memory.words[w + 1 + 3 * i] = t.prims[n].edges[i].a;
                memory.words[w + 2 + 3 * i] = t.prims[n].edges[i].b;
                memory.words[w + 3 + 3 * i] = t.prims[n].edges[i].c;
            end
        end
    endtask

    // Coverage rule applied to each pixel on its own
    function automatic void model_stamps(input test_t t);
        raster_prim_t  p;
        raster_stamp_t s;
        int            px;
        int            py;
        logic          covered;
        expected.delete();
        for (int n = 0; n < int'(t.count); n++) begin
            p = t.prims[n];
            for (int qy = 0; qy < QUADS_PER_SIDE; qy++) begin
                for (int qx = 0; qx < QUADS_PER_SIDE; qx++) begin
                    s.pos_x = raster_pos_t'(int'(p.x_loc) * (1 << TILE_LOGSIZE) + 2 * qx);
                    s.pos_y = raster_pos_t'(int'(p.y_loc) * (1 << TILE_LOGSIZE) + 2 * qy);
                    s.pid   = p.pid;
                    s.mask  = '0;
                    for (int k = 0; k < 4; k++) begin
                        px      = int'(s.pos_x) + k % 2;
                        py      = int'(s.pos_y) + k / 2;
                        covered = 1'b1;
                        for (int i = 0; i < 3; i++) begin
                            if (p.edges[i].a * px + p.edges[i].b * py + p.edges[i].c < 0) begin
                                covered = 1'b0;
                            end
                        end
                        s.mask[k] = covered;
                    end
                    if (s.mask != '0) begin
                        expected.push_back(s);
                    end
                end
            end
        end
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        #2;
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
    endtask

    task automatic run_test(input int idx);
        test_t t;
        int    got;
        int    errs;
        bit    done;
        t    = tests[idx];
        got  = 0;
        errs = 0;
        done = 1'b0;
        model_stamps(t);
        dcrs.prim_base  = t.base;
        dcrs.prim_count = t.count;
        apply_reset();
        store_records(t);
        while (!done) begin
            @(posedge clk);
            #2;
            rnd              = lcg_next(rnd);
            raster_req_ready = int'(rnd[30:16] % 100) >= int'(t.bp_pct);
            @(negedge clk);
            if (raster_req_valid && raster_req_ready) begin
                if (raster_req_empty) begin
                    done = 1'b1;
                    if (got != expected.size()) begin
                        $display("Fail at %0t: test %0d empty marker after %0d of %0d stamps",
                                 $time, idx, got, expected.size());
                        errs++;
                    end
                end else begin
                    if (got >= expected.size()) begin
                        $display("Fail at %0t: test %0d extra stamp x=%0d y=%0d pid=%h",
                                 $time, idx, raster_req_stamp.pos_x, raster_req_stamp.pos_y,
                                 raster_req_stamp.pid);
                        errs++;
                    end else if (raster_req_stamp !== expected[got]) begin
                        $display("Fail at %0t: test %0d stamp %0d got %0d,%0d m%h p%h",
                                 $time, idx, got, raster_req_stamp.pos_x, raster_req_stamp.pos_y,
                                 raster_req_stamp.mask, raster_req_stamp.pid,
                                 " exp %0d,%0d m%h p%h",
                                 expected[got].pos_x, expected[got].pos_y,
                                 expected[got].mask, expected[got].pid);
                        errs++;
                    end
                    got++;
                end
            end
        end
        // Marker must hold whatever ready does
        repeat (HOLD_CYCLES) begin
            @(posedge clk);
            #2;
            raster_req_ready = ~raster_req_ready;
            @(negedge clk);
            if (!(raster_req_valid && raster_req_empty)) begin
                $display("Fail at %0t: test %0d empty marker dropped", $time, idx);
                errs++;
            end
        end
        if (memory.req_count != int'(t.count) * PRIM_WORDS) begin
            $display("Fail at %0t: test %0d made %0d memory requests, expected %0d",
                     $time, idx, memory.req_count, int'(t.count) * PRIM_WORDS);
            errs++;
        end
        $display("test %0d: %0d of %0d stamps, %0d errors", idx, got, expected.size(), errs);
        errors += errs;
        if (errs != 0) begin
            failed++;
        end
    endtask

    initial begin
        #(NUM_TESTS * 2000 * CYCLE_NS);
        $display("Watchdog expired: the run went past %0d cycles without finishing",
                 NUM_TESTS * 2000);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        reset            = 1'b1;
        dcrs             = '0;
        raster_req_ready = 1'b0;
        rnd              = 32'd45749;
        errors           = 0;
        failed           = 0;
        fill_table();
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(i);
        end
        $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
